// ==== stat_core.f ====
source/stat_pkg.sv
source/stat_arb_mux.sv
source/stat_counter_ram.sv
source/stat_ctrl.sv
source/stat_core.sv
test/stat_checker.sv
test/tb_stat_core.sv

// ==== Bender.yml ====
package:
  name: stat_core

sources:
  - source/stat_pkg.sv
  - source/stat_arb_mux.sv
  - source/stat_counter_ram.sv
  - source/stat_ctrl.sv
  - source/stat_core.sv
  - target: test
    files:
      - test/stat_checker.sv
      - test/tb_stat_core.sv

// ==== test/tb_stat_core.sv ====
// Statistics core testbench
module tb_stat_core;

localparam int SRC_CNT = 4;
localparam int STAT_ID_W = 4;
localparam int NUM_CNT = 2**STAT_ID_W;
localparam int CLK_PERIOD = 8;
localparam int T3_BURST = 40;
localparam int WRAP_BURST = 16385;  // Four sources of 0xffff pass 2^32.
localparam int T6_BURST = 30;
localparam int HOST_TXN = 6 * NUM_CNT + 17;
localparam int INC_TXN = 12 + SRC_CNT * (T3_BURST + WRAP_BURST + T6_BURST);
localparam int LIMIT_CYCLES = 50 * (HOST_TXN + INC_TXN) + 2000;

logic                  clk_125mhz = 1'b0;
logic                  arst_n;
stat_pkg::stat_inc_t   src_inc [SRC_CNT];
logic [SRC_CNT-1:0]    src_valid;
logic [SRC_CNT-1:0]    src_ready;
stat_pkg::axil_req_t   axil_req;
stat_pkg::axil_rsp_t   axil_rsp;
int                    err_count;
int                    check_count;
int                    err_mark = 0;
int                    test_no = 0;
integer                seed;

always #(CLK_PERIOD / 2) clk_125mhz = ~clk_125mhz;

stat_core #(
    .SRC_CNT(SRC_CNT),
    .STAT_ID_W(STAT_ID_W)
)
stat_core_inst (
    .clk_125mhz(clk_125mhz),
    .arst_n(arst_n),
    .src_inc(src_inc),
    .src_valid(src_valid),
    .src_ready(src_ready),
    .axil_req(axil_req),
    .axil_rsp(axil_rsp)
);

stat_checker #(
    .SRC_CNT(SRC_CNT),
    .STAT_ID_W(STAT_ID_W)
)
checker_inst (
    .clk_125mhz(clk_125mhz),
    .arst_n(arst_n),
    .src_inc(src_inc),
    .src_valid(src_valid),
    .src_ready(src_ready),
    .axil_req(axil_req),
    .axil_rsp(axil_rsp),
    .err_count(err_count),
    .check_count(check_count)
);

task automatic axi_read(input stat_pkg::axil_addr_t addr, input bit bp);
    @(negedge clk_125mhz);
    axil_req.araddr = addr;
    axil_req.arvalid = 1'b1;
    do @(posedge clk_125mhz); while (!axil_rsp.arready);
    @(negedge clk_125mhz);
    axil_req.arvalid = 1'b0;
    forever begin
        axil_req.rready = !bp || (($random(seed) & 3) == 0);  // Random stall.
        @(posedge clk_125mhz);
        if (axil_rsp.rvalid && axil_req.rready) break;
        @(negedge clk_125mhz);
    end
    @(negedge clk_125mhz);
    axil_req.rready = 1'b0;
endtask

// Order 0 sends AW and W together, 1 sends AW first, 2 sends W first.
task automatic axi_write(input stat_pkg::axil_addr_t addr, input int order, input bit bp);
    bit aw_done;
    bit w_done;
    aw_done = 1'b0;
    w_done = 1'b0;
    @(negedge clk_125mhz);
    axil_req.awaddr = addr;
    axil_req.wdata = $random(seed);
    axil_req.awvalid = (order != 2);
    axil_req.wvalid = (order != 1);
    while (!(aw_done && w_done)) begin
        @(posedge clk_125mhz);
        if (axil_req.awvalid && axil_rsp.awready) aw_done = 1'b1;
        if (axil_req.wvalid && axil_rsp.wready) w_done = 1'b1;
        @(negedge clk_125mhz);
        axil_req.awvalid = !aw_done && (order != 2 || w_done);
        axil_req.wvalid = !w_done && (order != 1 || aw_done);
    end
    forever begin
        axil_req.bready = !bp || (($random(seed) & 3) == 0);
        @(posedge clk_125mhz);
        if (axil_rsp.bvalid && axil_req.bready) break;
        @(negedge clk_125mhz);
    end
    @(negedge clk_125mhz);
    axil_req.bready = 1'b0;
endtask

task automatic read_all(input bit bp);
    for (int n = 0; n < NUM_CNT; n++) begin
        axi_read(stat_pkg::axil_addr_t'(4 * n), bp);
    end
endtask

// Back-to-back increments from one source to ids base through base + span - 1.
task automatic send_burst(input int src, input int count, input int span, input int base,
                          input bit full);
    stat_pkg::stat_inc_t item;
    for (int n = 0; n < count; n++) begin
        @(negedge clk_125mhz);
        item.id = stat_pkg::stat_id_t'(base + ($unsigned($random(seed)) % span));
        item.inc = full ? 16'hffff : stat_pkg::stat_inc_val_t'($random(seed));
        src_inc[src] = item;
        src_valid[src] = 1'b1;
        do @(posedge clk_125mhz); while (!src_ready[src]);
    end
    @(negedge clk_125mhz);
    src_valid[src] = 1'b0;
endtask

task automatic run_sources(input int count, input int span, input int base, input bit full);
    for (int s = 0; s < SRC_CNT; s++) begin
        fork
            automatic int k = s;
            send_burst(k, count, span, base, full);
        join_none
    end
    wait fork;
endtask

task automatic report_test(input string name);
    test_no++;
    $display("Test %0d %s: %0d errors", test_no, name, err_count - err_mark);
    err_mark = err_count;
endtask

initial begin
    #(CLK_PERIOD * LIMIT_CYCLES);
    $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
    $display("Checks failed");
    $finish;
end

initial begin
    seed = 32'hf1c5;
    arst_n = 1'b0;
    axil_req = '0;
    src_valid = '0;
    for (int s = 0; s < SRC_CNT; s++) begin
        src_inc[s] = '0;
    end
    repeat (8) @(negedge clk_125mhz);
    arst_n = 1'b1;

    read_all(1'b0);
    report_test("reset values");

    send_burst(0, 12, 4, 0, 1'b0);
    read_all(1'b0);
    report_test("single source sums");

    run_sources(T3_BURST, 4, 0, 1'b0);
    read_all(1'b0);
    report_test("all sources round robin");

    axi_write(16'h000c, 0, 1'b0);
    axi_read(16'h000c, 1'b0);
    run_sources(WRAP_BURST, 1, 3, 1'b1);  // Counter 3 wraps.
    axi_write(16'h0004, 1, 1'b0);
    axi_write(16'h0008, 2, 1'b0);
    read_all(1'b0);
    report_test("clear and wrap");

    // Bad writes alias counters 3 and 0, which hold nonzero sums.
    axi_read(16'h0002, 1'b0);
    axi_read(16'h0040, 1'b0);
    axi_write(16'h000e, 0, 1'b0);
    axi_write(16'h004c, 1, 1'b0);
    axi_write(16'h8000, 2, 1'b0);
    read_all(1'b0);
    report_test("bad addresses");

    fork
        run_sources(T6_BURST, 256, 0, 1'b0);
        for (int i = 0; i < 4; i++) begin
            axi_write(stat_pkg::axil_addr_t'(12 * i), i % 3, 1'b1);
            axi_read(stat_pkg::axil_addr_t'(8 * i + 4), 1'b1);
        end
    join
    read_all(1'b1);
    report_test("host back-pressure");

    $display("Checks run: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
        $display("All checks passed");
    end else begin
        $display("Checks failed");
    end
    $finish;
end

endmodule

// ==== test/stat_checker.sv ====
// Statistics core result checker
module stat_checker #
(
    parameter SRC_CNT = 4,
    parameter STAT_ID_W = 4
)
(
    input  wire                      clk_125mhz,
    input  wire                      arst_n,

    input  wire stat_pkg::stat_inc_t src_inc [SRC_CNT],
    input  wire [SRC_CNT-1:0]        src_valid,
    input  wire [SRC_CNT-1:0]        src_ready,

    input  wire stat_pkg::axil_req_t axil_req,
    input  wire stat_pkg::axil_rsp_t axil_rsp,

    output int                       err_count,
    output int                       check_count
);

localparam int NUM_CNT = 2**STAT_ID_W;
localparam longint WRAP = 64'h1_0000_0000;

stat_pkg::stat_count_t model [NUM_CNT];  // Expected counter values.
int                    wait_cnt [SRC_CNT];
int                    run_cycles;
stat_pkg::axil_addr_t  rd_addr_q;
stat_pkg::axil_addr_t  wr_addr_q;
stat_pkg::axil_data_t  rdata_q;
bit                    stall_q;

// Expected data and response of a host access at addr.
function automatic stat_pkg::stat_count_t expect_read(input stat_pkg::axil_addr_t addr,
                                                      output stat_pkg::axil_resp_t resp);
    if (addr[1:0] != 2'b00 || int'(addr >> 2) >= NUM_CNT) begin
        resp = stat_pkg::RESP_SLVERR;
        return '0;
    end
    resp = stat_pkg::RESP_OKAY;
    return model[addr >> 2];
endfunction

function automatic void apply_inc(input stat_pkg::stat_inc_t item);
    int idx;
    idx = int'(item.id) % NUM_CNT;  // Only the low id bits count.
    model[idx] = stat_pkg::stat_count_t'((longint'(model[idx]) + longint'(item.inc)) % WRAP);
endfunction

function automatic void compare_value(input string name, input logic [31:0] exp,
                                      input logic [31:0] got);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("[ERROR] %s: expected 0x%08h, got 0x%08h", name, exp, got);
    end
endfunction

always @(posedge clk_125mhz) begin
    stat_pkg::stat_count_t exp_data;
    stat_pkg::axil_resp_t  exp_resp;
    bit                    any_grant;
    logic [2:0]            readies;
    if (!arst_n) begin
        for (int n = 0; n < NUM_CNT; n++) begin
            model[n] = '0;
        end
        for (int i = 0; i < SRC_CNT; i++) begin
            wait_cnt[i] = 0;
        end
        run_cycles = 0;
        stall_q = 1'b0;
        err_count = 0;
        check_count = 0;
    end else begin
        readies = {axil_rsp.arready, axil_rsp.awready, axil_rsp.wready};
        if (run_cycles == 0) begin
            // First edge out of reset sees the reset values.
            compare_value("src_ready", 32'h0, 32'(src_ready));
            compare_value("arready/awready/wready", 32'h0, 32'(readies));
            compare_value("bvalid/rvalid", 32'h0, 32'({axil_rsp.bvalid, axil_rsp.rvalid}));
        end else if (run_cycles == 1) begin
            compare_value("arready/awready/wready", 32'h7, 32'(readies));
        end
        if (run_cycles < 2) begin
            run_cycles++;
        end
        if (axil_req.arvalid && axil_rsp.arready) begin
            rd_addr_q = axil_req.araddr;
        end
        if (axil_req.awvalid && axil_rsp.awready) begin
            wr_addr_q = axil_req.awaddr;
        end
        if (axil_rsp.rvalid && stall_q) begin
            compare_value("rdata while stalled", rdata_q, axil_rsp.rdata);
        end
        stall_q = axil_rsp.rvalid && !axil_req.rready;
        rdata_q = axil_rsp.rdata;
        if (axil_rsp.rvalid && axil_req.rready) begin
            exp_data = expect_read(rd_addr_q, exp_resp);
            compare_value("rresp", 32'(exp_resp), 32'(axil_rsp.rresp));
            if (exp_resp == stat_pkg::RESP_OKAY) begin
                compare_value("rdata", exp_data, axil_rsp.rdata);
            end
        end
        if (axil_rsp.bvalid && axil_req.bready) begin
            exp_data = expect_read(wr_addr_q, exp_resp);
            compare_value("bresp", 32'(exp_resp), 32'(axil_rsp.bresp));
            if (exp_resp == stat_pkg::RESP_OKAY) begin
                model[wr_addr_q >> 2] = '0;  // Write clears.
            end
        end
        any_grant = |(src_valid & src_ready);
        for (int i = 0; i < SRC_CNT; i++) begin
            if (src_valid[i] && src_ready[i]) begin
                apply_inc(src_inc[i]);
                wait_cnt[i] = 0;
            end else if (src_valid[i] && any_grant) begin
                wait_cnt[i]++;  // Passed over by another source.
                if (wait_cnt[i] > SRC_CNT - 1) begin
                    err_count++;
                    $display("Round robin broken: source %0d passed over by %0d grants",
                             i, wait_cnt[i]);
                end
            end else if (!src_valid[i]) begin
                wait_cnt[i] = 0;
            end
        end
    end
end

endmodule

// ==== source/stat_core.sv ====
// Statistics collection top level
module stat_core #
(
    parameter SRC_CNT = 4,
    parameter STAT_ID_W = 4
)
(
    input  wire                      clk_125mhz,
    input  wire                      arst_n,

    input  wire stat_pkg::stat_inc_t src_inc [SRC_CNT],
    input  wire [SRC_CNT-1:0]        src_valid,
    output logic [SRC_CNT-1:0]       src_ready,

    input  wire stat_pkg::axil_req_t axil_req,
    output stat_pkg::axil_rsp_t      axil_rsp
);

stat_pkg::stat_inc_t   inc;
logic                  inc_valid;
logic                  inc_ready;
logic                  pipe_hold;
logic                  pipe_busy;
logic                  init_done;
logic                  host_op_valid;
logic                  host_op_clear;
stat_pkg::stat_id_t    host_id;
stat_pkg::stat_count_t host_rdata;

stat_arb_mux #(
    .SRC_CNT(SRC_CNT)
)
stat_arb_mux_inst (
    .clk_125mhz(clk_125mhz),
    .arst_n(arst_n),
    .src_inc(src_inc),
    .src_valid(src_valid),
    .src_ready(src_ready),
    .inc(inc),
    .inc_valid(inc_valid),
    .inc_ready(inc_ready)
);

stat_ctrl #(
    .STAT_ID_W(STAT_ID_W)
)
stat_ctrl_inst (
    .clk_125mhz(clk_125mhz),
    .arst_n(arst_n),
    .axil_req(axil_req),
    .axil_rsp(axil_rsp),
    .pipe_hold(pipe_hold),
    .pipe_busy(pipe_busy),
    .init_done(init_done),
    .host_op_valid(host_op_valid),
    .host_op_clear(host_op_clear),
    .host_id(host_id),
    .host_rdata(host_rdata)
);

stat_counter_ram #(
    .STAT_ID_W(STAT_ID_W)
)
stat_counter_ram_inst (
    .clk_125mhz(clk_125mhz),
    .arst_n(arst_n),
    .inc(inc),
    .inc_valid(inc_valid),
    .inc_ready(inc_ready),
    .pipe_hold(pipe_hold),
    .pipe_busy(pipe_busy),
    .host_op_valid(host_op_valid),
    .host_op_clear(host_op_clear),
    .host_id(host_id),
    .host_rdata(host_rdata),
    .init_done(init_done)
);

endmodule

// ==== source/stat_ctrl.sv ====
// AXI4-Lite host access control
module stat_ctrl #
(
    parameter STAT_ID_W = 4
)
(
    input  wire                         clk_125mhz,
    input  wire                         arst_n,

    input  wire stat_pkg::axil_req_t    axil_req,
    output stat_pkg::axil_rsp_t         axil_rsp,

    output logic                        pipe_hold,
    input  wire                         pipe_busy,
    input  wire                         init_done,

    output logic                        host_op_valid,
    output logic                        host_op_clear,
    output stat_pkg::stat_id_t          host_id,
    input  wire stat_pkg::stat_count_t  host_rdata
);

typedef enum logic [2:0] {
    ST_IDLE,
    ST_DRAIN,
    ST_ACCESS,
    ST_CAPTURE,
    ST_RD_RESP,
    ST_WR_RESP
} state_t;

state_t               state;
state_t               state_next;
logic                 run_q;
logic                 aw_seen;
logic                 w_seen;
logic                 ar_hs;
logic                 aw_hs;
logic                 w_hs;
logic                 wr_start;
stat_pkg::axil_addr_t aw_addr_q;
stat_pkg::stat_id_t   op_id_q;
logic                 op_write_q;
stat_pkg::axil_resp_t resp_q;
stat_pkg::axil_data_t rdata_q;

// Word aligned and inside the counter range.
function automatic logic addr_ok(stat_pkg::axil_addr_t addr);
    return (addr[1:0] == 2'b00) && ((addr >> 2) < (2**STAT_ID_W));
endfunction

function automatic stat_pkg::stat_id_t addr_id(stat_pkg::axil_addr_t addr);
    return stat_pkg::stat_id_t'(addr[STAT_ID_W+1:2]);
endfunction

always_comb begin
    axil_rsp.arready = (state == ST_IDLE) && run_q;
    axil_rsp.awready = (state == ST_IDLE) && run_q && !aw_seen;
    axil_rsp.wready = (state == ST_IDLE) && run_q && !w_seen;
    axil_rsp.bvalid = (state == ST_WR_RESP);
    axil_rsp.bresp = resp_q;
    axil_rsp.rvalid = (state == ST_RD_RESP);
    axil_rsp.rdata = rdata_q;
    axil_rsp.rresp = resp_q;
end

assign ar_hs = axil_rsp.arready && axil_req.arvalid;
assign aw_hs = axil_rsp.awready && axil_req.awvalid;
assign w_hs = axil_rsp.wready && axil_req.wvalid;
assign wr_start = (state == ST_IDLE) && aw_seen && w_seen && !ar_hs;  // Read wins.

assign pipe_hold = (state != ST_IDLE);
assign host_op_valid = (state == ST_ACCESS);
assign host_op_clear = op_write_q;
assign host_id = op_id_q;

always_comb begin
    state_next = state;
    case (state)
        ST_IDLE: begin
            if (ar_hs) begin
                state_next = addr_ok(axil_req.araddr) ? ST_DRAIN : ST_RD_RESP;
            end else if (wr_start) begin
                state_next = addr_ok(aw_addr_q) ? ST_DRAIN : ST_WR_RESP;
            end
        end
        ST_DRAIN: begin
            if (init_done && !pipe_busy) begin
                state_next = ST_ACCESS;
            end
        end
        ST_ACCESS: state_next = op_write_q ? ST_WR_RESP : ST_CAPTURE;
        ST_CAPTURE: state_next = ST_RD_RESP;
        ST_RD_RESP: begin
            if (axil_req.rready) begin
                state_next = ST_IDLE;
            end
        end
        ST_WR_RESP: begin
            if (axil_req.bready) begin
                state_next = ST_IDLE;
            end
        end
        default: state_next = ST_IDLE;
    endcase
end

always_ff @(posedge clk_125mhz or negedge arst_n) begin
    if (!arst_n) begin
        state <= ST_IDLE;
        run_q <= 1'b0;
        aw_seen <= 1'b0;
        w_seen <= 1'b0;
    end else begin
        state <= state_next;
        run_q <= 1'b1;  // Readies come up one cycle out of reset.
        if (aw_hs) begin
            aw_seen <= 1'b1;
        end else if (wr_start) begin
            aw_seen <= 1'b0;
        end
        if (w_hs) begin
            w_seen <= 1'b1;
        end else if (wr_start) begin
            w_seen <= 1'b0;
        end
    end
end

always_ff @(posedge clk_125mhz) begin
    if (aw_hs) begin
        aw_addr_q <= axil_req.awaddr;
    end
    if (ar_hs) begin
        op_write_q <= 1'b0;
        op_id_q <= addr_id(axil_req.araddr);
        resp_q <= addr_ok(axil_req.araddr) ? stat_pkg::RESP_OKAY : stat_pkg::RESP_SLVERR;
        rdata_q <= '0;  // Error reads return zero.
    end else if (wr_start) begin
        op_write_q <= 1'b1;
        op_id_q <= addr_id(aw_addr_q);
        resp_q <= addr_ok(aw_addr_q) ? stat_pkg::RESP_OKAY : stat_pkg::RESP_SLVERR;
    end
    if (state == ST_CAPTURE) begin
        rdata_q <= host_rdata;
    end
end

endmodule

// ==== source/stat_counter_ram.sv ====
// Counter memory with read-modify-write pipeline
module stat_counter_ram #
(
    parameter STAT_ID_W = 4
)
(
    input  wire                        clk_125mhz,
    input  wire                        arst_n,

    input  wire stat_pkg::stat_inc_t   inc,
    input  wire                        inc_valid,
    output logic                       inc_ready,

    input  wire                        pipe_hold,
    output logic                       pipe_busy,

    input  wire                        host_op_valid,
    input  wire                        host_op_clear,
    input  wire stat_pkg::stat_id_t    host_id,
    output stat_pkg::stat_count_t      host_rdata,
    output logic                       init_done
);

localparam DEPTH = 2**STAT_ID_W;

typedef logic [STAT_ID_W-1:0] addr_t;

stat_pkg::stat_count_t   mem [DEPTH];

addr_t                   init_ptr;
logic                    s1_valid;
logic                    s2_valid;
addr_t                   s1_id;
addr_t                   s2_id;
stat_pkg::stat_inc_val_t s1_inc;
stat_pkg::stat_inc_val_t s2_inc;
addr_t                   rd_addr;
addr_t                   host_addr;
stat_pkg::stat_count_t   rd_q;
stat_pkg::stat_count_t   fwd_data_q;
stat_pkg::stat_count_t   s2_sum;
logic                    fwd_q;
logic                    inc_accept;

assign inc_ready = init_done && !pipe_hold;
assign inc_accept = inc_valid && inc_ready;
assign pipe_busy = s1_valid || s2_valid;

assign host_addr = host_id[STAT_ID_W-1:0];
assign rd_addr = host_op_valid ? host_addr : s1_id;  // Pipeline is empty on host access.
assign host_rdata = rd_q;

// Stage two adds to either the stored or the forwarded value.
assign s2_sum = (fwd_q ? fwd_data_q : rd_q) + stat_pkg::stat_count_t'(s2_inc);

always_ff @(posedge clk_125mhz or negedge arst_n) begin
    if (!arst_n) begin
        init_ptr <= '0;
        init_done <= 1'b0;
        s1_valid <= 1'b0;
        s2_valid <= 1'b0;
    end else begin
        if (!init_done) begin
            init_ptr <= init_ptr + 1'b1;
            if (init_ptr == '1) begin
                init_done <= 1'b1;  // Sweep finished.
            end
        end
        s1_valid <= inc_accept;
        s2_valid <= s1_valid;
    end
end

always_ff @(posedge clk_125mhz) begin
    s1_id <= inc.id[STAT_ID_W-1:0];
    s1_inc <= inc.inc;
    s2_id <= s1_id;
    s2_inc <= s1_inc;

    rd_q <= mem[rd_addr];
    // Write of the same id lands on this edge, so the read is stale.
    fwd_q <= s2_valid && (s2_id == s1_id);
    fwd_data_q <= s2_sum;

    if (!init_done) begin
        mem[init_ptr] <= '0;
    end else if (host_op_valid && host_op_clear) begin
        mem[host_addr] <= '0;
    end else if (s2_valid) begin
        mem[s2_id] <= s2_sum;
    end
end

endmodule

// ==== source/stat_arb_mux.sv ====
// Round-robin increment merge
module stat_arb_mux #
(
    parameter SRC_CNT = 4
)
(
    input  wire                      clk_125mhz,
    input  wire                      arst_n,

    input  wire stat_pkg::stat_inc_t src_inc [SRC_CNT],
    input  wire [SRC_CNT-1:0]        src_valid,
    output logic [SRC_CNT-1:0]       src_ready,

    output stat_pkg::stat_inc_t      inc,
    output logic                     inc_valid,
    input  wire                      inc_ready
);

localparam IDX_W = $clog2(SRC_CNT);

logic [IDX_W-1:0] last_q;      // Index of the last winner.
logic [IDX_W-1:0] grant_idx;
logic             grant_found;

// Search starts one past the last winner.
always_comb begin
    int slot;
    grant_found = 1'b0;
    grant_idx = '0;
    for (int i = 1; i <= SRC_CNT; i++) begin
        slot = (int'(last_q) + i) % SRC_CNT;
        if (!grant_found && src_valid[slot]) begin
            grant_found = 1'b1;
            grant_idx = IDX_W'(slot);
        end
    end
end

assign inc = src_inc[grant_idx];
assign inc_valid = grant_found;

always_comb begin
    src_ready = '0;
    if (grant_found && inc_ready) begin
        src_ready[grant_idx] = 1'b1;  // Only the winner sees ready.
    end
end

always_ff @(posedge clk_125mhz or negedge arst_n) begin
    if (!arst_n) begin
        last_q <= IDX_W'(SRC_CNT - 1);  // Source 0 goes first.
    end else if (inc_valid && inc_ready) begin
        last_q <= grant_idx;
    end
end

endmodule

// ==== source/stat_pkg.sv ====
// Statistics block shared types
package stat_pkg;

    // Counter index, modules use the low STAT_ID_W bits.
    typedef logic [7:0] stat_id_t;

    // Increment amount and counter value.
    typedef logic [15:0] stat_inc_val_t;
    typedef logic [31:0] stat_count_t;  // Wraps modulo 2^32.

    // One increment request.
    typedef struct packed {
        stat_id_t      id;
        stat_inc_val_t inc;
    } stat_inc_t;

    // AXI4-Lite widths.
    typedef logic [15:0] axil_addr_t;  // Byte address.
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'd0;
    localparam axil_resp_t RESP_SLVERR = 2'd2;

    // Manager to subordinate, no wstrb.
    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        axil_data_t wdata;
        logic       bready;
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_req_t;

    // Subordinate to manager.
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_t bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_t rresp;
    } axil_rsp_t;

endpackage
